/* source/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int ADDR_SIZE     = 32;
    localparam int WORD_SIZE     = 32;
    localparam int REG_ADDR_SIZE = 5;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // funct3 / funct7 values that are decoded
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } instr_u;

endpackage : rv_core_pkg

`default_nettype wire

/* source/rv_register_file.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_register_file
    import rv_core_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [REG_ADDR_SIZE-1:0] raddr_a_i,
    input  logic [REG_ADDR_SIZE-1:0] raddr_b_i,
    input  logic                     we_i,
    input  logic [REG_ADDR_SIZE-1:0] waddr_i,
    input  logic [WORD_SIZE-1:0]     wdata_i,
    output logic [WORD_SIZE-1:0]     data_a_o,
    output logic [WORD_SIZE-1:0]     data_b_o
);

    logic [WORD_SIZE-1:0] regs_q [2**REG_ADDR_SIZE];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_SIZE; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            // x0 is never written, so it reads back as zero
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign data_a_o = regs_q[raddr_a_i];
    assign data_b_o = regs_q[raddr_b_i];

endmodule : rv_register_file

`default_nettype wire

/* source/rv_mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_mem_arbiter
    import rv_core_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Fetch side
    input  logic                 if_req_i,
    input  logic [ADDR_SIZE-1:0] if_addr_i,
    output logic                 if_rdy_o,
    // Data side
    input  logic                 dc_rd_i,
    input  logic                 dc_wr_i,
    input  logic [ADDR_SIZE-1:0] dc_addr_i,
    input  logic [WORD_SIZE-1:0] dc_wdata_i,
    output logic                 dc_rdy_o,
    output logic [WORD_SIZE-1:0] rdata_o,
    // Main memory
    input  logic                 mm_data_rdy_i,
    input  logic [WORD_SIZE-1:0] mm_rd_data_i,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o,
    output logic [ADDR_SIZE-1:0] mm_addr_o,
    output logic [ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic [WORD_SIZE-1:0] mm_wr_data_o
);

    localparam logic [1:0] OWN_NONE = 2'd0;
    localparam logic [1:0] OWN_IF   = 2'd1;
    localparam logic [1:0] OWN_DC   = 2'd2;

    logic [1:0] owner_q;
    logic [1:0] owner;

    // A new request claims the port, an open one keeps it
    always_comb begin
        if (owner_q != OWN_NONE) begin
            owner = owner_q;
        end else if (dc_rd_i || dc_wr_i) begin
            owner = OWN_DC;
        end else if (if_req_i) begin
            owner = OWN_IF;
        end else begin
            owner = OWN_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= mm_data_rdy_i ? OWN_NONE : owner;
        end
    end

    assign mm_rd_o      = (owner == OWN_IF && if_req_i) || (owner == OWN_DC && dc_rd_i);
    assign mm_wr_o      = (owner == OWN_DC) && dc_wr_i;
    assign mm_addr_o    = (owner == OWN_DC) ? dc_addr_i : if_addr_i;
    assign mm_wr_addr_o = dc_addr_i;
    assign mm_wr_data_o = dc_wdata_i;

    assign if_rdy_o = (owner == OWN_IF) && mm_data_rdy_i;
    assign dc_rdy_o = (owner == OWN_DC) && mm_data_rdy_i;
    assign rdata_o  = mm_rd_data_i;

    a_one_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({if_req_i, dc_rd_i, dc_wr_i}));

endmodule : rv_mem_arbiter

`default_nettype wire

/* source/rv_fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_fetch_stage
    import rv_core_pkg::*;
#(
    parameter logic [ADDR_SIZE-1:0] BOOT_ADDR = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Retire from the memory stage
    input  logic                 retire_i,
    input  logic [ADDR_SIZE-1:0] retire_pc_i,
    // Memory port through the arbiter
    input  logic                 mem_rdy_i,
    input  logic [WORD_SIZE-1:0] mem_rdata_i,
    output logic                 mem_req_o,
    output logic [ADDR_SIZE-1:0] mem_addr_o,
    // To decode
    output logic                 valid_o,
    output instr_u               instr_o,
    output logic [ADDR_SIZE-1:0] pc_o
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WAIT = 1'b1;

    logic                 state_q;
    logic                 boot_q;
    logic [ADDR_SIZE-1:0] pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            boot_q  <= 1'b1;
            pc_q    <= BOOT_ADDR;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (retire_i) begin
                pc_q <= retire_pc_i;
            end
            case (state_q)
                // First fetch after reset, then one per retired instruction
                ST_IDLE: begin
                    if (boot_q || retire_i) begin
                        state_q <= ST_WAIT;
                        boot_q  <= 1'b0;
                    end
                end
                default: begin
                    if (mem_rdy_i) begin
                        state_q <= ST_IDLE;
                        valid_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_WAIT && mem_rdy_i) begin
            instr_o <= mem_rdata_i;
        end
    end

    assign mem_req_o  = (state_q == ST_WAIT);
    assign mem_addr_o = pc_q;
    // PC stays put until the instruction retires
    assign pc_o       = pc_q;

    // An open request keeps its address until ready
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_rdy_i |=> mem_req_o && $stable(mem_addr_o));

endmodule : rv_fetch_stage

`default_nettype wire

/* source/rv_decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode_stage
    import rv_core_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // From fetch
    input  logic                     valid_i,
    input  instr_u                   instr_i,
    input  logic [ADDR_SIZE-1:0]     pc_i,
    // Register file read ports
    input  logic [WORD_SIZE-1:0]     rf_data_a_i,
    input  logic [WORD_SIZE-1:0]     rf_data_b_i,
    output logic [REG_ADDR_SIZE-1:0] rf_raddr_a_o,
    output logic [REG_ADDR_SIZE-1:0] rf_raddr_b_o,
    // To execute
    output logic                     valid_o,
    output logic [ADDR_SIZE-1:0]     pc_o,
    output logic [WORD_SIZE-1:0]     op_a_o,
    output logic [WORD_SIZE-1:0]     op_b_o,
    output logic [WORD_SIZE-1:0]     imm_o,
    output logic [REG_ADDR_SIZE-1:0] rd_o,
    output alu_op_e                  alu_op_o,
    output logic                     alu_src_imm_o,
    output logic                     rf_we_o,
    output logic                     load_o,
    output logic                     store_o,
    output logic                     branch_o
);

    logic [WORD_SIZE-1:0] imm_d;
    alu_op_e              alu_op_d;
    logic                 src_imm_d;
    logic                 we_d;
    logic                 load_d;
    logic                 store_d;
    logic                 branch_d;

    // rs1 and rs2 sit at the same bits in every format
    assign rf_raddr_a_o = instr_i.r.rs1;
    assign rf_raddr_b_o = instr_i.r.rs2;

    always_comb begin
        imm_d     = '0;
        alu_op_d  = ALU_ADD;
        src_imm_d = 1'b0;
        we_d      = 1'b0;
        load_d    = 1'b0;
        store_d   = 1'b0;
        branch_d  = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP: begin
                we_d = 1'b1;
                case ({instr_i.r.funct7, instr_i.r.funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op_d = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}:  alu_op_d = ALU_SUB;
                    {F7_BASE, F3_XOR}:     alu_op_d = ALU_XOR;
                    {F7_BASE, F3_OR}:      alu_op_d = ALU_OR;
                    {F7_BASE, F3_AND}:     alu_op_d = ALU_AND;
                    default:               we_d = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // ADDI only
                we_d      = (instr_i.i.funct3 == F3_ADD_SUB);
                src_imm_d = 1'b1;
                imm_d     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            OPC_LOAD: begin
                we_d   = (instr_i.i.funct3 == F3_WORD);
                load_d = (instr_i.i.funct3 == F3_WORD);
                imm_d  = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            OPC_STORE: begin
                store_d = (instr_i.s.funct3 == F3_WORD);
                imm_d   = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            end
            OPC_BRANCH: begin
                branch_d = (instr_i.b.funct3 == F3_BEQ);
                imm_d    = {{19{instr_i.b.imm_12}}, instr_i.b.imm_12, instr_i.b.imm_11,
                            instr_i.b.imm_10_5, instr_i.b.imm_4_1, 1'b0};
            end
            // Anything else flows on with no flags and retires as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            pc_o          <= pc_i;
            op_a_o        <= rf_data_a_i;
            op_b_o        <= rf_data_b_i;
            imm_o         <= imm_d;
            rd_o          <= instr_i.r.rd;
            alu_op_o      <= alu_op_d;
            alu_src_imm_o <= src_imm_d;
            rf_we_o       <= we_d;
            load_o        <= load_d;
            store_o       <= store_d;
            branch_o      <= branch_d;
        end
    end

endmodule : rv_decode_stage

`default_nettype wire

/* source/rv_execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_execute_stage
    import rv_core_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // From decode
    input  logic                     valid_i,
    input  logic [ADDR_SIZE-1:0]     pc_i,
    input  logic [WORD_SIZE-1:0]     op_a_i,
    input  logic [WORD_SIZE-1:0]     op_b_i,
    input  logic [WORD_SIZE-1:0]     imm_i,
    input  logic [REG_ADDR_SIZE-1:0] rd_i,
    input  alu_op_e                  alu_op_i,
    input  logic                     alu_src_imm_i,
    input  logic                     rf_we_i,
    input  logic                     load_i,
    input  logic                     store_i,
    input  logic                     branch_i,
    // To the memory stage
    output logic                     valid_o,
    output logic [WORD_SIZE-1:0]     result_o,
    output logic [WORD_SIZE-1:0]     store_data_o,
    output logic [REG_ADDR_SIZE-1:0] rd_o,
    output logic                     rf_we_o,
    output logic                     load_o,
    output logic                     store_o,
    output logic [ADDR_SIZE-1:0]     next_pc_o
);

    logic [WORD_SIZE-1:0] alu_b;
    logic [WORD_SIZE-1:0] alu_res;
    logic [ADDR_SIZE-1:0] next_pc_d;

    assign alu_b = alu_src_imm_i ? imm_i : op_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_SUB: alu_res = op_a_i - alu_b;
            ALU_AND: alu_res = op_a_i & alu_b;
            ALU_OR:  alu_res = op_a_i | alu_b;
            ALU_XOR: alu_res = op_a_i ^ alu_b;
            default: alu_res = op_a_i + alu_b;
        endcase
    end

    // BEQ compares the two register operands
    assign next_pc_d = (branch_i && op_a_i == op_b_i) ? pc_i + imm_i : pc_i + 32'd4;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            // Loads and stores carry the effective address
            result_o     <= (load_i || store_i) ? op_a_i + imm_i : alu_res;
            store_data_o <= op_b_i;
            rd_o         <= rd_i;
            rf_we_o      <= rf_we_i;
            load_o       <= load_i;
            store_o      <= store_i;
            next_pc_o    <= next_pc_d;
        end
    end

    a_ld_st_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i |-> !(load_i && store_i));

endmodule : rv_execute_stage

`default_nettype wire

/* source/rv_memory_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_memory_stage
    import rv_core_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // From execute
    input  logic                     valid_i,
    input  logic [WORD_SIZE-1:0]     result_i,
    input  logic [WORD_SIZE-1:0]     store_data_i,
    input  logic [REG_ADDR_SIZE-1:0] rd_i,
    input  logic                     rf_we_i,
    input  logic                     load_i,
    input  logic                     store_i,
    input  logic [ADDR_SIZE-1:0]     next_pc_i,
    // Data port through the arbiter
    input  logic                     mem_rdy_i,
    input  logic [WORD_SIZE-1:0]     mem_rdata_i,
    output logic                     mem_rd_o,
    output logic                     mem_wr_o,
    output logic [ADDR_SIZE-1:0]     mem_addr_o,
    output logic [WORD_SIZE-1:0]     mem_wdata_o,
    // Register file write and retire
    output logic                     rf_we_o,
    output logic [REG_ADDR_SIZE-1:0] rf_waddr_o,
    output logic [WORD_SIZE-1:0]     rf_wdata_o,
    output logic                     retire_o,
    output logic [ADDR_SIZE-1:0]     retire_pc_o
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACCESS = 2'd1;
    localparam logic [1:0] ST_RETIRE = 2'd2;

    logic [1:0]               state_q;
    logic [WORD_SIZE-1:0]     data_q;
    logic [WORD_SIZE-1:0]     sdata_q;
    logic [REG_ADDR_SIZE-1:0] rd_q;
    logic                     we_q;
    logic                     load_q;
    logic                     store_q;
    logic [ADDR_SIZE-1:0]     next_pc_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (valid_i) begin
                        state_q <= (load_i || store_i) ? ST_ACCESS : ST_RETIRE;
                    end
                end
                ST_ACCESS: begin
                    if (mem_rdy_i) begin
                        state_q <= ST_RETIRE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_q    <= result_i;
            sdata_q   <= store_data_i;
            rd_q      <= rd_i;
            we_q      <= rf_we_i;
            load_q    <= load_i;
            store_q   <= store_i;
            next_pc_q <= next_pc_i;
        end else if (state_q == ST_ACCESS && mem_rdy_i && load_q) begin
            // Address is no longer needed once the load data is back
            data_q <= mem_rdata_i;
        end
    end

    assign mem_rd_o    = (state_q == ST_ACCESS) && load_q;
    assign mem_wr_o    = (state_q == ST_ACCESS) && store_q;
    assign mem_addr_o  = data_q;
    assign mem_wdata_o = sdata_q;

    assign retire_o    = (state_q == ST_RETIRE);
    assign retire_pc_o = next_pc_q;
    assign rf_we_o     = retire_o && we_q;
    assign rf_waddr_o  = rd_q;
    assign rf_wdata_o  = data_q;

endmodule : rv_memory_stage

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
#(
    parameter logic [ADDR_SIZE-1:0] BOOT_ADDR = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    // Main memory
    input  logic                 mm_data_rdy_i,
    input  logic [WORD_SIZE-1:0] mm_rd_data_i,
    output logic [WORD_SIZE-1:0] mm_wr_data_o,
    output logic [ADDR_SIZE-1:0] mm_addr_o,
    output logic [ADDR_SIZE-1:0] mm_wr_addr_o,
    output logic                 mm_rd_o,
    output logic                 mm_wr_o
);

    // Arbiter side
    logic                     if_req;
    logic [ADDR_SIZE-1:0]     if_addr;
    logic                     if_rdy;
    logic                     dc_rd_req;
    logic                     dc_wr_req;
    logic [ADDR_SIZE-1:0]     dc_addr;
    logic [WORD_SIZE-1:0]     dc_wdata;
    logic                     dc_rdy;
    logic [WORD_SIZE-1:0]     mem_rdata;
    // Fetch to decode
    logic                     if_valid;
    instr_u                   if_instr;
    logic [ADDR_SIZE-1:0]     if_pc;
    // Register file reads
    logic [REG_ADDR_SIZE-1:0] rf_raddr_a;
    logic [REG_ADDR_SIZE-1:0] rf_raddr_b;
    logic [WORD_SIZE-1:0]     rf_data_a;
    logic [WORD_SIZE-1:0]     rf_data_b;
    // Decode to execute
    logic                     id_valid;
    logic [ADDR_SIZE-1:0]     id_pc;
    logic [WORD_SIZE-1:0]     id_op_a;
    logic [WORD_SIZE-1:0]     id_op_b;
    logic [WORD_SIZE-1:0]     id_imm;
    logic [REG_ADDR_SIZE-1:0] id_rd;
    alu_op_e                  id_alu_op;
    logic                     id_alu_src_imm;
    logic                     id_rf_we;
    logic                     id_load;
    logic                     id_store;
    logic                     id_branch;
    // Execute to memory
    logic                     ex_valid;
    logic [WORD_SIZE-1:0]     ex_result;
    logic [WORD_SIZE-1:0]     ex_store_data;
    logic [REG_ADDR_SIZE-1:0] ex_rd;
    logic                     ex_rf_we;
    logic                     ex_load;
    logic                     ex_store;
    logic [ADDR_SIZE-1:0]     ex_next_pc;
    // Writeback and retire
    logic                     rf_we;
    logic [REG_ADDR_SIZE-1:0] rf_waddr;
    logic [WORD_SIZE-1:0]     rf_wdata;
    logic                     retire;
    logic [ADDR_SIZE-1:0]     retire_pc;

    rv_fetch_stage #(
        .BOOT_ADDR (BOOT_ADDR)
    ) i_fetch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .retire_i    (retire),
        .retire_pc_i (retire_pc),
        .mem_rdy_i   (if_rdy),
        .mem_rdata_i (mem_rdata),
        .mem_req_o   (if_req),
        .mem_addr_o  (if_addr),
        .valid_o     (if_valid),
        .instr_o     (if_instr),
        .pc_o        (if_pc)
    );

    rv_decode_stage i_decode (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (if_valid),
        .instr_i       (if_instr),
        .pc_i          (if_pc),
        .rf_data_a_i   (rf_data_a),
        .rf_data_b_i   (rf_data_b),
        .rf_raddr_a_o  (rf_raddr_a),
        .rf_raddr_b_o  (rf_raddr_b),
        .valid_o       (id_valid),
        .pc_o          (id_pc),
        .op_a_o        (id_op_a),
        .op_b_o        (id_op_b),
        .imm_o         (id_imm),
        .rd_o          (id_rd),
        .alu_op_o      (id_alu_op),
        .alu_src_imm_o (id_alu_src_imm),
        .rf_we_o       (id_rf_we),
        .load_o        (id_load),
        .store_o       (id_store),
        .branch_o      (id_branch)
    );

    rv_execute_stage i_execute (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (id_valid),
        .pc_i          (id_pc),
        .op_a_i        (id_op_a),
        .op_b_i        (id_op_b),
        .imm_i         (id_imm),
        .rd_i          (id_rd),
        .alu_op_i      (id_alu_op),
        .alu_src_imm_i (id_alu_src_imm),
        .rf_we_i       (id_rf_we),
        .load_i        (id_load),
        .store_i       (id_store),
        .branch_i      (id_branch),
        .valid_o       (ex_valid),
        .result_o      (ex_result),
        .store_data_o  (ex_store_data),
        .rd_o          (ex_rd),
        .rf_we_o       (ex_rf_we),
        .load_o        (ex_load),
        .store_o       (ex_store),
        .next_pc_o     (ex_next_pc)
    );

    rv_memory_stage i_memory (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (ex_valid),
        .result_i     (ex_result),
        .store_data_i (ex_store_data),
        .rd_i         (ex_rd),
        .rf_we_i      (ex_rf_we),
        .load_i       (ex_load),
        .store_i      (ex_store),
        .next_pc_i    (ex_next_pc),
        .mem_rdy_i    (dc_rdy),
        .mem_rdata_i  (mem_rdata),
        .mem_rd_o     (dc_rd_req),
        .mem_wr_o     (dc_wr_req),
        .mem_addr_o   (dc_addr),
        .mem_wdata_o  (dc_wdata),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata),
        .retire_o     (retire),
        .retire_pc_o  (retire_pc)
    );

    rv_register_file i_rf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .data_a_o  (rf_data_a),
        .data_b_o  (rf_data_b)
    );

    rv_mem_arbiter i_arbiter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .if_req_i      (if_req),
        .if_addr_i     (if_addr),
        .if_rdy_o      (if_rdy),
        .dc_rd_i       (dc_rd_req),
        .dc_wr_i       (dc_wr_req),
        .dc_addr_i     (dc_addr),
        .dc_wdata_i    (dc_wdata),
        .dc_rdy_o      (dc_rdy),
        .rdata_o       (mem_rdata),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_data_i  (mm_rd_data_i),
        .mm_rd_o       (mm_rd_o),
        .mm_wr_o       (mm_wr_o),
        .mm_addr_o     (mm_addr_o),
        .mm_wr_addr_o  (mm_wr_addr_o),
        .mm_wr_data_o  (mm_wr_data_o)
    );

endmodule : rv_core

`default_nettype wire

/* tb/rv_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    localparam int          NUM_TESTS   = 12;
    localparam int          MAX_CYCLES  = NUM_TESTS * 6 * 20;
    localparam int          MEM_WORDS   = 256;
    localparam logic [31:0] BOOT_ADDR   = 32'h0000_0040;
    localparam logic [31:0] RESULT_ADDR = 32'h0000_0100;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        mm_data_rdy = 1'b0;
    logic [31:0] mm_rd_data = '0;
    logic [31:0] mm_wr_data;
    logic [31:0] mm_addr;
    logic [31:0] mm_wr_addr;
    logic        mm_rd;
    logic        mm_wr;

    // Test table
    string       names    [NUM_TESTS];
    logic [31:0] instrs   [NUM_TESTS];
    logic [31:0] op_a     [NUM_TESTS];
    logic [31:0] op_b     [NUM_TESTS];
    logic [31:0] exp_addr [NUM_TESTS];
    logic [31:0] exp_data [NUM_TESTS];

    // Memory image for the next row, and the live memory
    logic [31:0] image [MEM_WORDS];
    logic [31:0] mem   [MEM_WORDS];
    logic [31:0] rng_q = 32'hb6e9df74;
    logic [2:0]  wait_left;
    logic        busy_q = 1'b0;
    int          cycle_cnt = 0;
    int          n_checks = 0;
    int          n_errors = 0;

    always #5 clk = ~clk;

    rv_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) i_rv_core (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .mm_data_rdy_i (mm_data_rdy),
        .mm_rd_data_i  (mm_rd_data),
        .mm_wr_data_o  (mm_wr_data),
        .mm_addr_o     (mm_addr),
        .mm_wr_addr_o  (mm_wr_addr),
        .mm_rd_o       (mm_rd),
        .mm_wr_o       (mm_wr)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Every word differs, and the low bits never form a supported opcode
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h1357_9BDF;
    endfunction

    function automatic logic [31:0] rtype_instr(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd);
        // rd = x1 op x2
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_instr(input logic [6:0] opc, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_instr(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic set_row(input int idx, input string name, input logic [31:0] instr,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] addr, input logic [31:0] data);
        names[idx]    = name;
        instrs[idx]   = instr;
        op_a[idx]     = a;
        op_b[idx]     = b;
        exp_addr[idx] = addr;
        exp_data[idx] = data;
    endtask

    // ADDI x1, ADDI x2, test, SW of the test's rd field, then the BEQ target
    task automatic load_program(input int idx);
        logic [7:0] base;
        base = BOOT_ADDR[9:2];
        for (int k = 0; k < MEM_WORDS; k++) begin
            image[k] = fill_word(k * 4);
        end
        image[base]        = itype_instr(7'b0010011, 3'b000, 5'd1, 5'd0, op_a[idx][11:0]);
        image[base + 8'd1] = itype_instr(7'b0010011, 3'b000, 5'd2, 5'd0, op_b[idx][11:0]);
        image[base + 8'd2] = instrs[idx];
        image[base + 8'd3] = store_instr(instrs[idx][11:7], 5'd0, RESULT_ADDR[11:0]);
        image[base + 8'd4] = store_instr(5'd1, 5'd0, RESULT_ADDR[11:0]);
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        n_errors++;
        $display("error %s %s: expected %h, actual %h", name, what, exp, act);
    endtask

    // Memory model with 0 to 7 wait cycles before each ready pulse
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < MEM_WORDS; k++) begin
                mem[k] = image[k];
            end
            mm_data_rdy <= 1'b0;
            busy_q      <= 1'b0;
        end else if (mm_data_rdy) begin
            mm_data_rdy <= 1'b0;
            busy_q      <= 1'b0;
        end else if (mm_rd || mm_wr) begin
            if (!busy_q) begin
                rng_q     = xorshift32(rng_q);
                wait_left = rng_q[2:0];
            end
            busy_q <= 1'b1;
            if (wait_left == 3'd0) begin
                mm_data_rdy <= 1'b1;
                if (mm_wr) begin
                    mem[mm_wr_addr[9:2]] = mm_wr_data;
                end else begin
                    mm_rd_data <= mem[mm_addr[9:2]];
                end
            end else begin
                wait_left = wait_left - 3'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing all tests", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        set_row(0, "add", rtype_instr(7'h00, 3'b000, 5'd3), 32'h123, 32'h456, RESULT_ADDR,
                32'h0000_0579);
        set_row(1, "sub", rtype_instr(7'h20, 3'b000, 5'd3), 32'h100, 32'h234, RESULT_ADDR,
                32'hFFFF_FECC);
        set_row(2, "and", rtype_instr(7'h00, 3'b111, 5'd3), 32'h7F0, 32'h3CF, RESULT_ADDR,
                32'h0000_03C0);
        set_row(3, "or", rtype_instr(7'h00, 3'b110, 5'd3), 32'h500, 32'h0AA, RESULT_ADDR,
                32'h0000_05AA);
        set_row(4, "xor", rtype_instr(7'h00, 3'b100, 5'd3), 32'hFFF, 32'h555, RESULT_ADDR,
                32'hFFFF_FAAA);
        set_row(5, "addi", itype_instr(7'b0010011, 3'b000, 5'd3, 5'd1, 12'hFF0), 32'h045,
                32'h0, RESULT_ADDR, 32'h0000_0035);
        set_row(6, "x0_write", itype_instr(7'b0010011, 3'b000, 5'd0, 5'd1, 12'h07F), 32'h321,
                32'h0, RESULT_ADDR, 32'h0);
        // 0x300 - 4 reads the fill word at 0x2FC
        set_row(7, "lw", itype_instr(7'b0000011, 3'b010, 5'd3, 5'd1, 12'hFFC), 32'h300,
                32'h0, RESULT_ADDR, 32'h11AB_9BDF);
        // Taken stores x1 from the target, not taken stores the unwritten x8
        set_row(8, "beq_taken", branch_instr(13'd8), 32'h05A, 32'h05A, RESULT_ADDR,
                32'h0000_005A);
        set_row(9, "beq_not_taken", branch_instr(13'd8), 32'h05A, 32'h05B, RESULT_ADDR,
                32'h0);
        set_row(10, "sw_neg_offset", store_instr(5'd2, 5'd1, 12'hFF0), 32'h210, 32'hEDD,
                32'h0000_0200, 32'hFFFF_FEDD);
        set_row(11, "sw_pos_offset", store_instr(5'd2, 5'd1, 12'h024), 32'h1C0, 32'h6B5,
                32'h0000_01E4, 32'h0000_06B5);

        for (int i = 0; i < NUM_TESTS; i++) begin
            load_program(i);
            @(posedge clk);
            rst_n <= 1'b0;
            @(posedge clk);
            @(negedge clk);
            n_checks++;
            if (mm_rd !== 1'b0 || mm_wr !== 1'b0) begin
                n_errors++;
                $display("error %s: memory request active during reset", names[i]);
            end
            @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            while (mm_rd !== 1'b1) begin
                @(negedge clk);
            end
            n_checks++;
            if (mm_addr !== BOOT_ADDR) begin
                report_mismatch(names[i], "first fetch address", BOOT_ADDR, mm_addr);
            end
            while (mm_wr !== 1'b1) begin
                @(negedge clk);
            end
            n_checks++;
            if (mm_wr_addr !== exp_addr[i]) begin
                report_mismatch(names[i], "store address", exp_addr[i], mm_wr_addr);
            end
            n_checks++;
            if (mm_wr_data !== exp_data[i]) begin
                report_mismatch(names[i], "store data", exp_data[i], mm_wr_data);
            end
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : rv_core_tb

`default_nettype wire

/* rv_core.f */
source/rv_core_pkg.sv
source/rv_register_file.sv
source/rv_mem_arbiter.sv
source/rv_fetch_stage.sv
source/rv_decode_stage.sv
source/rv_execute_stage.sv
source/rv_memory_stage.sv
source/rv_core.sv
tb/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
